//--- rtl/cpu_pkg.sv
package cpu_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 32;
  localparam int reg_addr_width = $clog2(reg_count);
  localparam int dmem_words = 256;
  localparam int dmem_index_width = $clog2(dmem_words);

  localparam logic [xlen-1:0] reset_pc = '0;
  // addi x0, x0, 0
  localparam logic [31:0] nop_instruction = 32'h0000_0013;

  // major opcodes
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui = 7'b0110111;
  localparam logic [6:0] opcode_load = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_jal = 7'b1101111;
  localparam logic [6:0] opcode_jalr = 7'b1100111;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    branch_none, branch_beq, branch_bne, branch_blt, branch_bge, branch_jal, branch_jalr
  } branch_type_t;

  typedef enum logic {
    retire_reg_write, retire_store
  } retire_kind_t;

  typedef struct packed {
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rd;
    logic [xlen-1:0] immediate;
    alu_op_t alu_op;
    logic alu_use_rs2;
    logic reg_write;
    logic mem_read;
    logic mem_write;
    branch_type_t branch_type;
  } decoded_t;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    logic [31:0] instruction;
  } if_id_t;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    decoded_t decoded;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
  } id_ex_t;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] result;
    logic [xlen-1:0] store_data;
    logic [reg_addr_width-1:0] rd;
    logic reg_write;
    logic mem_read;
    logic mem_write;
  } ex_mem_t;

  typedef struct packed {
    logic valid;
    logic [reg_addr_width-1:0] rd;
    logic reg_write;
    logic [xlen-1:0] data;
  } mem_wb_t;

  typedef struct packed {
    logic valid;
    retire_kind_t kind;
    logic [reg_addr_width-1:0] rd;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
  } retire_t;

endpackage

//--- rtl/decoder.sv
`timescale 1ns/1ps

module decoder (
  input logic [31:0] instruction,
  output cpu_pkg::decoded_t decoded
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [cpu_pkg::xlen-1:0] imm_i;
  logic [cpu_pkg::xlen-1:0] imm_s;
  logic [cpu_pkg::xlen-1:0] imm_b;
  logic [cpu_pkg::xlen-1:0] imm_u;
  logic [cpu_pkg::xlen-1:0] imm_j;

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];

  // sign extended immediate formats
  assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
  assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                  instruction[30:25], instruction[11:8], 1'b0};
  assign imm_u = {instruction[31:12], 12'b0};
  assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                  instruction[20], instruction[30:21], 1'b0};

  always_comb begin
    // anything not matched below stays a no-op
    decoded = '0;
    decoded.rs1 = instruction[19:15];
    decoded.rs2 = instruction[24:20];
    decoded.rd = instruction[11:7];

    case (opcode)
      cpu_pkg::opcode_op: begin
        decoded.alu_use_rs2 = 1'b1;
        decoded.reg_write = 1'b1;
        case ({funct7, funct3})
          {cpu_pkg::funct7_base, 3'b000}: decoded.alu_op = cpu_pkg::alu_add;
          {cpu_pkg::funct7_alt, 3'b000}: decoded.alu_op = cpu_pkg::alu_sub;
          {cpu_pkg::funct7_base, 3'b111}: decoded.alu_op = cpu_pkg::alu_and;
          {cpu_pkg::funct7_base, 3'b110}: decoded.alu_op = cpu_pkg::alu_or;
          {cpu_pkg::funct7_base, 3'b100}: decoded.alu_op = cpu_pkg::alu_xor;
          {cpu_pkg::funct7_base, 3'b010}: decoded.alu_op = cpu_pkg::alu_slt;
          default: decoded.reg_write = 1'b0;
        endcase
      end
      cpu_pkg::opcode_op_imm: begin
        decoded.immediate = imm_i;
        decoded.reg_write = 1'b1;
        case (funct3)
          3'b000: decoded.alu_op = cpu_pkg::alu_add;
          3'b111: decoded.alu_op = cpu_pkg::alu_and;
          3'b110: decoded.alu_op = cpu_pkg::alu_or;
          3'b100: decoded.alu_op = cpu_pkg::alu_xor;
          3'b010: decoded.alu_op = cpu_pkg::alu_slt;
          default: decoded.reg_write = 1'b0;
        endcase
      end
      cpu_pkg::opcode_lui: begin
        decoded.immediate = imm_u;
        decoded.alu_op = cpu_pkg::alu_pass_b;
        decoded.reg_write = 1'b1;
      end
      cpu_pkg::opcode_load: begin
        // word loads only
        if (funct3 == 3'b010) begin
          decoded.immediate = imm_i;
          decoded.mem_read = 1'b1;
          decoded.reg_write = 1'b1;
        end
      end
      cpu_pkg::opcode_store: begin
        if (funct3 == 3'b010) begin
          decoded.immediate = imm_s;
          decoded.mem_write = 1'b1;
        end
      end
      cpu_pkg::opcode_branch: begin
        decoded.immediate = imm_b;
        case (funct3)
          3'b000: decoded.branch_type = cpu_pkg::branch_beq;
          3'b001: decoded.branch_type = cpu_pkg::branch_bne;
          3'b100: decoded.branch_type = cpu_pkg::branch_blt;
          3'b101: decoded.branch_type = cpu_pkg::branch_bge;
          default: decoded.branch_type = cpu_pkg::branch_none;
        endcase
      end
      cpu_pkg::opcode_jal: begin
        decoded.immediate = imm_j;
        decoded.branch_type = cpu_pkg::branch_jal;
        decoded.reg_write = 1'b1;
      end
      cpu_pkg::opcode_jalr: begin
        if (funct3 == 3'b000) begin
          decoded.immediate = imm_i;
          decoded.branch_type = cpu_pkg::branch_jalr;
          decoded.reg_write = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

//--- rtl/registers.sv
`timescale 1ns/1ps

module registers (
  input logic clock,
  input logic [cpu_pkg::reg_addr_width-1:0] rs1,
  input logic [cpu_pkg::reg_addr_width-1:0] rs2,
  input logic [cpu_pkg::reg_addr_width-1:0] rd,
  input logic [cpu_pkg::xlen-1:0] data,
  input logic reg_write,
  output logic [cpu_pkg::xlen-1:0] rs1_data,
  output logic [cpu_pkg::xlen-1:0] rs2_data
);

  logic [cpu_pkg::xlen-1:0] regs [cpu_pkg::reg_count];
  logic writing;

  assign writing = reg_write && (rd != '0);

  always_ff @(posedge clock) begin
    if (writing) begin
      regs[rd] <= data;
    end
  end

  // x0 reads zero, a same-cycle write reads through
  assign rs1_data = (rs1 == '0) ? '0 :
                    (writing && rd == rs1) ? data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (writing && rd == rs2) ? data : regs[rs2];

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
  input logic [cpu_pkg::xlen-1:0] a,
  input logic [cpu_pkg::xlen-1:0] b,
  input cpu_pkg::alu_op_t op,
  output logic [cpu_pkg::xlen-1:0] result
);

  logic less_signed;

  assign less_signed = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      cpu_pkg::alu_add: result = a + b;
      cpu_pkg::alu_sub: result = a - b;
      cpu_pkg::alu_and: result = a & b;
      cpu_pkg::alu_or: result = a | b;
      cpu_pkg::alu_xor: result = a ^ b;
      cpu_pkg::alu_slt: result = {{(cpu_pkg::xlen-1){1'b0}}, less_signed};
      // lui passes the shifted immediate
      cpu_pkg::alu_pass_b: result = b;
      default: result = '0;
    endcase
  end

endmodule

//--- rtl/branch.sv
`timescale 1ns/1ps

module branch (
  input logic [cpu_pkg::xlen-1:0] pc,
  input logic [cpu_pkg::xlen-1:0] rs1_data,
  input logic [cpu_pkg::xlen-1:0] rs2_data,
  input logic [cpu_pkg::xlen-1:0] immediate,
  input cpu_pkg::branch_type_t branch_type,
  input logic valid,
  output logic taken,
  output logic [cpu_pkg::xlen-1:0] target
);

  logic equal;
  logic less;
  logic condition;
  logic [cpu_pkg::xlen-1:0] jalr_sum;

  assign equal = rs1_data == rs2_data;
  assign less = $signed(rs1_data) < $signed(rs2_data);

  always_comb begin
    case (branch_type)
      cpu_pkg::branch_beq: condition = equal;
      cpu_pkg::branch_bne: condition = !equal;
      cpu_pkg::branch_blt: condition = less;
      cpu_pkg::branch_bge: condition = !less;
      cpu_pkg::branch_jal, cpu_pkg::branch_jalr: condition = 1'b1;
      default: condition = 1'b0;
    endcase
  end

  assign taken = valid && condition;

  // jalr drops bit 0 of the sum
  assign jalr_sum = rs1_data + immediate;
  assign target = (branch_type == cpu_pkg::branch_jalr) ? {jalr_sum[cpu_pkg::xlen-1:1], 1'b0}
                                                        : pc + immediate;

endmodule

//--- rtl/forwarding.sv
`timescale 1ns/1ps

module forwarding (
  input cpu_pkg::id_ex_t ex,
  input cpu_pkg::ex_mem_t mem,
  input logic [cpu_pkg::xlen-1:0] mem_load_data,
  input cpu_pkg::mem_wb_t wb,
  output logic [cpu_pkg::xlen-1:0] rs1_data_forwarded,
  output logic [cpu_pkg::xlen-1:0] rs2_data_forwarded
);

  logic mem_writes;
  logic wb_writes;
  logic [cpu_pkg::xlen-1:0] mem_value;

  // x0 is never a forwarding source
  assign mem_writes = mem.valid && mem.reg_write && (mem.rd != '0);
  assign wb_writes = wb.valid && wb.reg_write && (wb.rd != '0);

  // load data is already available in the memory stage
  assign mem_value = mem.mem_read ? mem_load_data : mem.result;

  function automatic logic [cpu_pkg::xlen-1:0] pick(
    input logic [cpu_pkg::reg_addr_width-1:0] rs,
    input logic [cpu_pkg::xlen-1:0] reg_value
  );
    if (mem_writes && mem.rd == rs) begin
      return mem_value;
    end else if (wb_writes && wb.rd == rs) begin
      return wb.data;
    end
    return reg_value;
  endfunction

  always_comb begin
    rs1_data_forwarded = pick(ex.decoded.rs1, ex.rs1_data);
    rs2_data_forwarded = pick(ex.decoded.rs2, ex.rs2_data);
  end

endmodule

//--- rtl/stage_register.sv
`timescale 1ns/1ps

module stage_register #(
  parameter type payload_t = cpu_pkg::if_id_t
) (
  input logic clock,
  input logic rst,
  input logic hold,
  input logic squash,
  input payload_t d,
  output payload_t q
);

  // only the valid bit is control state, the rest is payload
  always_ff @(posedge clock) begin
    if (rst || squash) begin
      q.valid <= 1'b0;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

//--- rtl/data_memory.sv
`timescale 1ns/1ps

module data_memory (
  input logic clock,
  input logic [cpu_pkg::xlen-1:0] addr,
  input logic [cpu_pkg::xlen-1:0] write_data,
  input logic write,
  output logic [cpu_pkg::xlen-1:0] read_data
);

  logic [cpu_pkg::xlen-1:0] words [cpu_pkg::dmem_words];
  logic [cpu_pkg::dmem_index_width-1:0] index;

  // word address, wraps at the memory size
  assign index = addr[cpu_pkg::dmem_index_width+1:2];

  initial begin
    for (int i = 0; i < cpu_pkg::dmem_words; i++) begin
      words[i] = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (write) begin
      words[index] <= write_data;
    end
  end

  assign read_data = words[index];

endmodule

//--- rtl/cpu.sv
`timescale 1ns/1ps

module cpu (
  input logic clock,
  input logic rst,
  output logic [cpu_pkg::xlen-1:0] imem_addr,
  input logic [31:0] imem_data,
  input logic imem_valid,
  output cpu_pkg::retire_t retire
);

  logic [cpu_pkg::xlen-1:0] pc;

  cpu_pkg::if_id_t if_id_d, if_id_q;
  cpu_pkg::decoded_t id_decoded;
  logic [cpu_pkg::xlen-1:0] id_rs1_data, id_rs2_data;

  cpu_pkg::id_ex_t id_ex_d, id_ex_q;
  logic [cpu_pkg::xlen-1:0] ex_rs1_forwarded, ex_rs2_forwarded;
  logic [cpu_pkg::xlen-1:0] ex_alu_b, ex_alu_result, ex_target;
  logic ex_taken;
  logic ex_is_jump;

  cpu_pkg::ex_mem_t ex_mem_d, ex_mem_q;
  logic [cpu_pkg::xlen-1:0] mem_load_data;

  cpu_pkg::mem_wb_t mem_wb_d, mem_wb_q;

  logic store_valid;
  logic [cpu_pkg::xlen-1:0] store_addr, store_data;
  cpu_pkg::retire_t retire_next;

  // fetch
  assign imem_addr = pc;

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= cpu_pkg::reset_pc;
    end else if (ex_taken) begin
      pc <= ex_target;
    end else if (imem_valid) begin
      pc <= pc + 4;
    end
  end

  // a withheld word becomes a bubble
  assign if_id_d.valid = imem_valid;
  assign if_id_d.pc = pc;
  assign if_id_d.instruction = imem_valid ? imem_data : cpu_pkg::nop_instruction;

  stage_register #(.payload_t(cpu_pkg::if_id_t)) if_id_register (
    .clock(clock),
    .rst(rst),
    .hold(1'b0),
    .squash(ex_taken),
    .d(if_id_d),
    .q(if_id_q)
  );

  // decode
  decoder decoder (
    .instruction(if_id_q.instruction),
    .decoded(id_decoded)
  );

  registers registers (
    .clock(clock),
    .rs1(id_decoded.rs1),
    .rs2(id_decoded.rs2),
    .rd(mem_wb_q.rd),
    .data(mem_wb_q.data),
    .reg_write(mem_wb_q.valid && mem_wb_q.reg_write),
    .rs1_data(id_rs1_data),
    .rs2_data(id_rs2_data)
  );

  assign id_ex_d = '{valid: if_id_q.valid, pc: if_id_q.pc, decoded: id_decoded,
                     rs1_data: id_rs1_data, rs2_data: id_rs2_data};

  stage_register #(.payload_t(cpu_pkg::id_ex_t)) id_ex_register (
    .clock(clock),
    .rst(rst),
    .hold(1'b0),
    .squash(ex_taken),
    .d(id_ex_d),
    .q(id_ex_q)
  );

  // execute
  forwarding forwarding (
    .ex(id_ex_q),
    .mem(ex_mem_q),
    .mem_load_data(mem_load_data),
    .wb(mem_wb_q),
    .rs1_data_forwarded(ex_rs1_forwarded),
    .rs2_data_forwarded(ex_rs2_forwarded)
  );

  assign ex_alu_b = id_ex_q.decoded.alu_use_rs2 ? ex_rs2_forwarded : id_ex_q.decoded.immediate;

  alu alu (
    .a(ex_rs1_forwarded),
    .b(ex_alu_b),
    .op(id_ex_q.decoded.alu_op),
    .result(ex_alu_result)
  );

  branch branch (
    .pc(id_ex_q.pc),
    .rs1_data(ex_rs1_forwarded),
    .rs2_data(ex_rs2_forwarded),
    .immediate(id_ex_q.decoded.immediate),
    .branch_type(id_ex_q.decoded.branch_type),
    .valid(id_ex_q.valid),
    .taken(ex_taken),
    .target(ex_target)
  );

  // jumps write the return address
  assign ex_is_jump = (id_ex_q.decoded.branch_type == cpu_pkg::branch_jal) ||
                      (id_ex_q.decoded.branch_type == cpu_pkg::branch_jalr);

  assign ex_mem_d = '{valid: id_ex_q.valid,
                      result: ex_is_jump ? id_ex_q.pc + 4 : ex_alu_result,
                      store_data: ex_rs2_forwarded,
                      rd: id_ex_q.decoded.rd,
                      reg_write: id_ex_q.decoded.reg_write,
                      mem_read: id_ex_q.decoded.mem_read,
                      mem_write: id_ex_q.decoded.mem_write};

  stage_register #(.payload_t(cpu_pkg::ex_mem_t)) ex_mem_register (
    .clock(clock),
    .rst(rst),
    .hold(1'b0),
    .squash(1'b0),
    .d(ex_mem_d),
    .q(ex_mem_q)
  );

  // memory
  data_memory data_memory (
    .clock(clock),
    .addr(ex_mem_q.result),
    .write_data(ex_mem_q.store_data),
    .write(ex_mem_q.valid && ex_mem_q.mem_write),
    .read_data(mem_load_data)
  );

  assign mem_wb_d = '{valid: ex_mem_q.valid, rd: ex_mem_q.rd, reg_write: ex_mem_q.reg_write,
                      data: ex_mem_q.mem_read ? mem_load_data : ex_mem_q.result};

  stage_register #(.payload_t(cpu_pkg::mem_wb_t)) mem_wb_register (
    .clock(clock),
    .rst(rst),
    .hold(1'b0),
    .squash(1'b0),
    .d(mem_wb_d),
    .q(mem_wb_q)
  );

  // store info follows the store into the writeback slot,
  // so both kinds of retire leave from one place in program order
  always_ff @(posedge clock) begin
    if (rst) begin
      store_valid <= 1'b0;
    end else begin
      store_valid <= ex_mem_q.valid && ex_mem_q.mem_write;
    end
    store_addr <= ex_mem_q.result;
    store_data <= ex_mem_q.store_data;
  end

  always_comb begin
    retire_next = '0;
    if (mem_wb_q.valid && mem_wb_q.reg_write && mem_wb_q.rd != '0) begin
      retire_next.valid = 1'b1;
      retire_next.kind = cpu_pkg::retire_reg_write;
      retire_next.rd = mem_wb_q.rd;
      retire_next.data = mem_wb_q.data;
    end else if (store_valid) begin
      retire_next.valid = 1'b1;
      retire_next.kind = cpu_pkg::retire_store;
      retire_next.addr = store_addr;
      retire_next.data = store_data;
    end
  end

  // registered on the edge of the register file write
  always_ff @(posedge clock) begin
    if (rst) begin
      retire.valid <= 1'b0;
    end else begin
      retire <= retire_next;
    end
  end

endmodule

//--- sim/cpu_properties.sv
`timescale 1ns/1ps

module cpu_properties (
  input logic clock,
  input logic rst,
  input logic [cpu_pkg::xlen-1:0] imem_addr,
  input logic imem_valid,
  input logic ex_taken,
  input cpu_pkg::retire_t retire
);

  int failures = 0;

  // retire register clears on the first reset edge
  retire_quiet_in_reset: assert property (@(posedge clock) rst |=> !retire.valid)
    else begin
      failures++;
      $error("retire valid is high during reset");
    end

  fetch_aligned: assert property (@(posedge clock) disable iff (rst)
      imem_addr[1:0] == 2'b00)
    else begin
      failures++;
      $error("fetch address is not word aligned");
    end

  // pc only moves on an accepted word or a redirect
  fetch_held: assert property (@(posedge clock) disable iff (rst)
      !imem_valid && !ex_taken |=> $stable(imem_addr))
    else begin
      failures++;
      $error("fetch address moved while no word was accepted");
    end

  no_x0_retire: assert property (@(posedge clock) disable iff (rst)
      retire.valid && retire.kind == cpu_pkg::retire_reg_write |-> retire.rd != '0)
    else begin
      failures++;
      $error("register write retire names x0");
    end

endmodule

bind cpu cpu_properties cpu_checks (
  .clock(clock),
  .rst(rst),
  .imem_addr(imem_addr),
  .imem_valid(imem_valid),
  .ex_taken(ex_taken),
  .retire(retire)
);

//--- sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

  localparam int max_words = 256;
  localparam int drain_cycles = 20;

  logic clock;
  logic rst;
  logic [cpu_pkg::xlen-1:0] imem_addr;
  logic [31:0] imem_data;
  logic imem_valid;
  cpu_pkg::retire_t retire;

  logic [31:0] instr_words [max_words];
  int program_length;
  cpu_pkg::retire_t expected [$];
  int error_count;
  int retire_count;
  logic trace_loaded = 1'b0;

  cpu dut (
    .clock(clock),
    .rst(rst),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .imem_valid(imem_valid),
    .retire(retire)
  );

  always #10 clock = ~clock;

  function automatic logic [31:0] instruction_at(input logic [cpu_pkg::xlen-1:0] addr);
    if ($isunknown(addr) || addr[cpu_pkg::xlen-1:2] >= program_length) begin
      return cpu_pkg::nop_instruction;
    end
    return instr_words[addr[9:2]];
  endfunction

  // instruction memory read follows the fetch address
  always @(imem_addr) begin
    imem_data <= instruction_at(imem_addr);
  end

  // withhold about one fetch in four
  initial begin
    void'($urandom(3));
    forever begin
      @(posedge clock);
      imem_valid <= ($urandom % 4) != 0;
    end
  end

  task automatic load_trace();
    int fd;
    int fields;
    string line;
    byte tag;
    logic [31:0] first;
    logic [31:0] second;
    cpu_pkg::retire_t entry;
    for (int i = 0; i < max_words; i++) begin
      instr_words[i] = cpu_pkg::nop_instruction;
    end
    fd = $fopen("sim/cpu_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file sim/cpu_trace.txt");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin
        fields = $sscanf(line, "%c %h %h", tag, first, second);
        entry = '0;
        entry.valid = 1'b1;
        entry.data = second;
        if (fields != 3) begin
          $display("unreadable trace line: %s", line);
          error_count++;
        end else if (tag == "I" && first < max_words * 4) begin
          instr_words[first[9:2]] = second;
          if (int'(first[31:2]) + 1 > program_length) begin
            program_length = int'(first[31:2]) + 1;
          end
        end else if (tag == "W") begin
          entry.kind = cpu_pkg::retire_reg_write;
          entry.rd = first[cpu_pkg::reg_addr_width-1:0];
          expected.push_back(entry);
        end else if (tag == "S") begin
          entry.kind = cpu_pkg::retire_store;
          entry.addr = first;
          expected.push_back(entry);
        end else begin
          $display("trace line with an unknown tag or an address out of range: %s", line);
          error_count++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic compare_reg_write(input cpu_pkg::retire_t actual,
                                   input cpu_pkg::retire_t wanted);
    if (actual.rd !== wanted.rd) begin
      $display("Mismatch retire.rd: expected 0x%h, got 0x%h at %0t", wanted.rd, actual.rd, $time);
      error_count++;
    end
    if (actual.data !== wanted.data) begin
      $display("Mismatch retire.data: expected 0x%h, got 0x%h at %0t",
               wanted.data, actual.data, $time);
      error_count++;
    end
  endtask

  task automatic compare_store(input cpu_pkg::retire_t actual, input cpu_pkg::retire_t wanted);
    if (actual.addr !== wanted.addr) begin
      $display("Mismatch retire.addr: expected 0x%h, got 0x%h at %0t",
               wanted.addr, actual.addr, $time);
      error_count++;
    end
    if (actual.data !== wanted.data) begin
      $display("Mismatch retire.data: expected 0x%h, got 0x%h at %0t",
               wanted.data, actual.data, $time);
      error_count++;
    end
  endtask

  task automatic check_retire();
    cpu_pkg::retire_t wanted;
    if (retire.valid === 1'b1) begin
      retire_count++;
      if (expected.size() == 0) begin
        $display("a retire arrived after the last expected one at %0t", $time);
        error_count++;
      end else begin
        wanted = expected.pop_front();
        if (retire.kind !== wanted.kind) begin
          $display("a %s retired where a %s was expected at %0t",
                   retire.kind == cpu_pkg::retire_store ? "store" : "register write",
                   wanted.kind == cpu_pkg::retire_store ? "store" : "register write", $time);
          error_count++;
        end else if (wanted.kind == cpu_pkg::retire_store) begin
          compare_store(retire, wanted);
        end else begin
          compare_reg_write(retire, wanted);
        end
      end
    end else if (retire.valid !== 1'b0) begin
      $display("retire valid is unknown at %0t", $time);
      error_count++;
    end
  endtask

  task automatic finish_run();
    error_count += dut.cpu_checks.failures;
    $display("retires checked: %0d, errors: %0d", retire_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  initial begin
    clock = 1'b0;
    rst = 1'b1;
    imem_valid = 1'b0;
    imem_data = cpu_pkg::nop_instruction;
    error_count = 0;
    retire_count = 0;
    program_length = 0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (8) @(posedge clock);
    rst <= 1'b0;
    while (expected.size() != 0) begin
      @(posedge clock);
      check_retire();
    end
    // stray retires after the last expected one
    repeat (drain_cycles) begin
      @(posedge clock);
      check_retire();
    end
    finish_run();
  end

  // watchdog scaled to the program length
  initial begin
    wait (trace_loaded === 1'b1);
    repeat (8 * program_length + 200) @(posedge clock);
    $display("timeout: %0d expected retires still missing", expected.size());
    error_count++;
    finish_run();
  end

endmodule

//--- sim/cpu_trace.txt
# columns: tag, then two hex fields
# I = byte address, instruction; W = rd, data; S = byte address, data
# alu chain with back to back dependencies
I 00000000 00500093
I 00000004 00708113
I 00000008 002081B3
I 0000000C 40118233
I 00000010 003262B3
I 00000014 FFD00313
I 00000018 001323B3
I 0000001C 0FF3C413
I 00000020 0F047493
I 00000024 00A4E513
I 00000028 123455B7
I 0000002C 00132613
I 00000030 00A5C6B3
# write to x0, no retire
I 00000034 00908013
# store, load, use of the loaded value
I 00000038 00D02823
I 0000003C 01002703
I 00000040 001707B3
# branches, the two words after a taken one never retire
I 00000044 00208463
I 00000048 00100813
I 0000004C 00209663
I 00000050 01100893
I 00000054 01200913
I 00000058 00134663
I 0000005C 01300993
I 00000060 01400A13
I 00000064 00135463
I 00000068 00200A93
I 0000006C 0060D663
I 00000070 01600B13
I 00000074 01700B93
I 00000078 0060C463
I 0000007C 00411463
I 00000080 00410663
I 00000084 01800C13
I 00000088 01900C93
# jal, then jalr with bit 0 of the target set
I 0000008C 00C00D6F
I 00000090 01B00D93
I 00000094 01C00E13
I 00000098 0A100E93
I 0000009C 008E8F67
I 000000A0 02B00D93
I 000000A4 02C00E13
I 000000A8 01ED0FB3
I 000000AC 01F02A23
# park on a jump to itself
I 000000B0 0000006F
# expected retires in program order
W 01 00000005
W 02 0000000C
W 03 00000011
W 04 0000000C
W 05 0000001D
W 06 FFFFFFFD
W 07 00000001
W 08 000000FE
W 09 000000F0
W 0A 000000FA
W 0B 12345000
W 0C 00000001
W 0D 123450FA
S 00000010 123450FA
W 0E 123450FA
W 0F 123450FF
W 10 00000001
W 15 00000002
W 1A 00000090
W 1D 000000A1
W 1E 000000A0
W 1F 00000130
S 00000014 00000130

//--- project.f
rtl/cpu_pkg.sv
rtl/decoder.sv
rtl/registers.sv
rtl/alu.sv
rtl/branch.sv
rtl/forwarding.sv
rtl/stage_register.sv
rtl/data_memory.sv
rtl/cpu.sv
sim/cpu_properties.sv
sim/cpu_tb.sv
